/* all.f */
enigma_pkg.sv
button_press.sv
key_press_fsm.sv
scan_to_letter.sv
rotor_settings.sv
enigma_cipher.sv
letter_to_seg7.sv
enigma_top.sv
tb_enigma.sv

/* run.sh */
#!/bin/sh
# build and run the enigma testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_enigma -f all.f -o sim_enigma
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_enigma
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

/* tb_enigma.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_enigma import enigma_pkg::*; ();

    localparam int HOLDOFF_CYCLES = 8;
    // three strobed bytes, lamp settle, stray byte, holdoff wait
    localparam int KEY_CYCLES     = HOLDOFF_CYCLES + 14;
    // four low, four high
    localparam int PRESS_CYCLES   = 10;
    localparam int NUM_KEYS       = 31;
    localparam int NUM_PRESSES    = 31;
    localparam int TEST_CYCLES    = 16 + NUM_KEYS * KEY_CYCLES + NUM_PRESSES * PRESS_CYCLES;

    // set 2 make codes, index is the letter
    localparam logic [7:0] KEY_CODE [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
        8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };

    logic                       CLOCK_50;
    logic                       i_rst_n;
    logic [7:0]                 i_scan_code;
    logic                       i_scan_strobe;
    logic [NUM_SET_BUTTONS-1:0] i_btn_n;
    logic [6:0]                 o_hex0;
    logic [6:0]                 o_hex1;
    logic [6:0]                 o_hex2;
    logic [6:0]                 o_hex3;
    logic [6:0]                 o_hex4;
    logic [6:0]                 o_hex5;
    lamp_t                      o_lamp;

    // reference machine, index 0 left, 1 middle, 2 right
    int          m_num  [3];
    int          m_ring [3];
    int          m_pos  [3];
    logic [31:0] lcg_state;

    enigma_top #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) dut_i (
        .CLOCK_50      (CLOCK_50),
        .i_rst_n       (i_rst_n),
        .i_scan_code   (i_scan_code),
        .i_scan_strobe (i_scan_strobe),
        .i_btn_n       (i_btn_n),
        .o_hex0        (o_hex0),
        .o_hex1        (o_hex1),
        .o_hex2        (o_hex2),
        .o_hex3        (o_hex3),
        .o_hex4        (o_hex4),
        .o_hex5        (o_hex5),
        .o_lamp        (o_lamp)
    );

    function automatic int lcg_letter();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[23:16]) % 26;
    endfunction

    function automatic logic [31:0] glyph_of(input int l);
        return 32'(SEG7_GLYPH[l]);
    endfunction

    function automatic int notch_of(input int r);
        return int'(ROTOR_NOTCH[m_num[r]]) - 65;
    endfunction

    // historical stepping, middle also moves off its own notch
    function automatic void model_step();
        bit right_turn;
        bit middle_turn;
        right_turn  = (m_pos[2] == notch_of(2));
        middle_turn = (m_pos[1] == notch_of(1));
        if (middle_turn) begin
            m_pos[0] = (m_pos[0] + 1) % 26;
        end
        if (middle_turn || right_turn) begin
            m_pos[1] = (m_pos[1] + 1) % 26;
        end
        m_pos[2] = (m_pos[2] + 1) % 26;
    endfunction

    // contact shifted by position minus ring
    function automatic int rotor_pass(input int c, input int r, input bit backward);
        int shift;
        int contact;
        int out;
        shift   = (m_pos[r] - m_ring[r] + 26) % 26;
        contact = (c + shift) % 26;
        out     = 0;
        if (!backward) begin
            out = int'(ROTOR_WIRING[m_num[r]][contact]) - 65;
        end else begin
            for (int k = 0; k < 26; k++) begin
                if (int'(ROTOR_WIRING[m_num[r]][k]) - 65 == contact) begin
                    out = k;
                end
            end
        end
        return (out - shift + 26) % 26;
    endfunction

    function automatic int encipher_letter(input int p);
        int c;
        c = p;
        for (int r = 2; r >= 0; r--) begin
            c = rotor_pass(c, r, 1'b0);
        end
        c = int'(REFLECTOR_B[c]) - 65;
        for (int r = 0; r < 3; r++) begin
            c = rotor_pass(c, r, 1'b1);
        end
        return c;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_positions();
        check_value(32'(o_hex5), glyph_of(m_pos[0]), "left position on HEX5");
        check_value(32'(o_hex4), glyph_of(m_pos[1]), "middle position on HEX4");
        check_value(32'(o_hex3), glyph_of(m_pos[2]), "right position on HEX3");
    endtask

    // held low long enough for sync and edge detect
    task automatic press_button(input int b);
        @(posedge CLOCK_50);
        i_btn_n <= ~(NUM_SET_BUTTONS'(1) << b);
        repeat (4) @(posedge CLOCK_50);
        i_btn_n <= '1;
        repeat (4) @(posedge CLOCK_50);
        case (b)
            0: m_num[2]  = (m_num[2] + 1) % 5;
            1: m_pos[2]  = (m_pos[2] + 1) % 26;
            2: m_ring[2] = (m_ring[2] + 1) % 26;
            3: m_num[1]  = (m_num[1] + 1) % 5;
            4: m_pos[1]  = (m_pos[1] + 1) % 26;
            5: m_ring[1] = (m_ring[1] + 1) % 26;
            6: m_num[0]  = (m_num[0] + 1) % 5;
            default: m_pos[0] = (m_pos[0] + 1) % 26;
        endcase
    endtask

    task automatic strobe_byte(input logic [7:0] code);
        @(posedge CLOCK_50);
        i_scan_code   <= code;
        i_scan_strobe <= 1'b1;
        @(posedge CLOCK_50);
        i_scan_strobe <= 1'b0;
    endtask

    // make, F0, break, then check and sit out the holdoff
    task automatic type_key(input logic [7:0] code, input bit stray, output int cipher);
        int    plain;
        lamp_t lamp_before;
        plain  = -1;
        cipher = -1;
        for (int k = 0; k < 26; k++) begin
            if (KEY_CODE[k] == code) begin
                plain = k;
            end
        end
        lamp_before = o_lamp;
        strobe_byte(code);
        strobe_byte(SCAN_BREAK);
        strobe_byte(code);
        // encipher pulse, then lamp registered one edge later
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        if (plain >= 0) begin
            model_step();
            cipher = encipher_letter(plain);
            check_value(32'(o_lamp), 32'd1 << cipher, "lamp after letter key");
            check_value(32'(o_hex2), glyph_of(cipher), "cipher letter on HEX2");
            check_value(32'(o_hex0), glyph_of(plain), "plaintext letter on HEX0");
        end else begin
            check_value(32'(o_lamp), 32'(lamp_before), "lamp after non-letter key");
            check_value(32'(o_hex0), 32'(SEG7_BLANK), "HEX0 for non-letter key");
        end
        check_positions();
        if (stray) begin
            // B make code inside the holdoff window
            strobe_byte(KEY_CODE[1]);
            @(negedge CLOCK_50);
            check_value(32'(o_hex0), glyph_of(plain), "HEX0 after byte in holdoff");
        end
        repeat (HOLDOFF_CYCLES + 2) @(posedge CLOCK_50);
    endtask

    task automatic test_reset_state();
        check_value(32'(o_lamp), 32'd0, "lamp after reset");
        check_value(32'(o_hex0), 32'(SEG7_BLANK), "HEX0 after reset");
        check_value(32'(o_hex1), 32'(SEG7_BLANK), "HEX1 after reset");
        check_value(32'(o_hex2), 32'(SEG7_BLANK), "HEX2 after reset");
        check_positions();
    endtask

    // AAAAA on I II III at AAA gives BDZGO
    task automatic test_known_vector();
        int expected [5] = '{1, 3, 25, 6, 14};
        int got;
        for (int i = 0; i < 5; i++) begin
            type_key(KEY_CODE[0], 1'b0, got);
            check_value(32'(got), 32'(expected[i]), "known vector letter");
        end
    endtask

    task automatic test_double_step();
        int got;
        int left_exp  [3] = '{0, 0, 1};
        int mid_exp   [3] = '{3, 4, 5};
        int right_exp [3] = '{21, 22, 23};
        while (m_pos[2] != 20) begin
            press_button(1);
        end
        while (m_pos[1] != 3) begin
            press_button(4);
        end
        while (m_pos[0] != 0) begin
            press_button(7);
        end
        check_positions();
        for (int i = 0; i < 3; i++) begin
            type_key(KEY_CODE[lcg_letter()], 1'b0, got);
            check_value(32'(o_hex5), glyph_of(left_exp[i]), "left during double step");
            check_value(32'(o_hex4), glyph_of(mid_exp[i]), "middle during double step");
            check_value(32'(o_hex3), glyph_of(right_exp[i]), "right during double step");
        end
    endtask

    task automatic test_numbers_rings();
        int got;
        // right V, middle IV, left II
        repeat (2) press_button(0);
        repeat (2) press_button(3);
        press_button(6);
        // right ring F, middle ring D
        repeat (5) press_button(2);
        repeat (3) press_button(5);
        for (int i = 0; i < 20; i++) begin
            type_key(KEY_CODE[lcg_letter()], 1'b0, got);
        end
    endtask

    task automatic test_non_letter_holdoff();
        int got;
        // digit 1 key
        type_key(8'h16, 1'b0, got);
        type_key(KEY_CODE[4], 1'b1, got);
        // a taken stray byte would block this one
        type_key(KEY_CODE[2], 1'b0, got);
    endtask

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        repeat (2 * TEST_CYCLES) @(posedge CLOCK_50);
        $display("Done: errors found");
        $fatal(1, "timeout, tests did not finish within %0d cycles", 2 * TEST_CYCLES);
    end

    initial begin
        i_rst_n       = 1'b0;
        i_scan_code   = 8'h00;
        i_scan_strobe = 1'b0;
        i_btn_n       = '1;
        lcg_state     = 32'h57bdf161;
        m_num         = '{0, 1, 2};
        m_ring        = '{0, 0, 0};
        m_pos         = '{0, 0, 0};
        repeat (2) @(posedge CLOCK_50);
        i_rst_n <= 1'b1;
        @(negedge CLOCK_50);
        test_reset_state();
        test_known_vector();
        test_double_step();
        test_numbers_rings();
        test_non_letter_holdoff();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* enigma_top.sv */
`timescale 1ns/100ps
`default_nettype none

module enigma_top import enigma_pkg::*; #(
    parameter int HOLDOFF_CYCLES = 5000
) (
    input  wire logic                       CLOCK_50,
    input  wire logic                       i_rst_n,
    input  wire logic [7:0]                 i_scan_code,
    input  wire logic                       i_scan_strobe,
    input  wire logic [NUM_SET_BUTTONS-1:0] i_btn_n,
    output logic      [6:0]                 o_hex0,
    output logic      [6:0]                 o_hex1,
    output logic      [6:0]                 o_hex2,
    output logic      [6:0]                 o_hex3,
    output logic      [6:0]                 o_hex4,
    output logic      [6:0]                 o_hex5,
    output lamp_t                           o_lamp
);

    logic [NUM_SET_BUTTONS-1:0] press;
    logic [7:0]                 held_code;
    logic                       encipher;
    shown_letter_t              plaintext;
    shown_letter_t              cipher;
    rotor_set_t                 rotors;
    shown_letter_t              pos_left;
    shown_letter_t              pos_middle;
    shown_letter_t              pos_right;

    // rotor windows always lit
    assign pos_left   = '{shown: 1'b1, letter: rotors.left.position};
    assign pos_middle = '{shown: 1'b1, letter: rotors.middle.position};
    assign pos_right  = '{shown: 1'b1, letter: rotors.right.position};
    // spacer digit between plain and cipher
    assign o_hex1     = SEG7_BLANK;

    button_press u_buttons (
        .CLOCK_50 (CLOCK_50),
        .i_rst_n  (i_rst_n),
        .i_btn_n  (i_btn_n),
        .o_press  (press)
    );

    key_press_fsm #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_keys (
        .CLOCK_50      (CLOCK_50),
        .i_rst_n       (i_rst_n),
        .i_scan_code   (i_scan_code),
        .i_scan_strobe (i_scan_strobe),
        .i_plain_shown (plaintext.shown),
        .o_held_code   (held_code),
        .o_encipher    (encipher)
    );

    scan_to_letter u_scan (
        .i_scan_code (held_code),
        .o_plain     (plaintext)
    );

    rotor_settings u_rotors (
        .CLOCK_50 (CLOCK_50),
        .i_rst_n  (i_rst_n),
        .i_press  (press),
        .i_step   (encipher),
        .o_rotors (rotors)
    );

    enigma_cipher u_cipher (
        .CLOCK_50   (CLOCK_50),
        .i_rst_n    (i_rst_n),
        .i_encipher (encipher),
        .i_plain    (plaintext),
        .i_rotors   (rotors),
        .o_cipher   (cipher),
        .o_lamp     (o_lamp)
    );

    letter_to_seg7 u_hex0 (.i_letter(plaintext),  .o_seg(o_hex0));
    letter_to_seg7 u_hex2 (.i_letter(cipher),     .o_seg(o_hex2));
    letter_to_seg7 u_hex3 (.i_letter(pos_right),  .o_seg(o_hex3));
    letter_to_seg7 u_hex4 (.i_letter(pos_middle), .o_seg(o_hex4));
    letter_to_seg7 u_hex5 (.i_letter(pos_left),   .o_seg(o_hex5));

endmodule

`default_nettype wire

/* letter_to_seg7.sv */
`timescale 1ns/100ps
`default_nettype none

module letter_to_seg7 import enigma_pkg::*; (
    input  wire shown_letter_t i_letter,
    output logic [6:0]         o_seg
);

    // glyph lookup, digit dark when nothing to show
    always_comb begin
        if (i_letter.shown) begin
            o_seg = SEG7_GLYPH[i_letter.letter];
        end else begin
            o_seg = SEG7_BLANK;
        end
    end

endmodule

`default_nettype wire

/* enigma_cipher.sv */
`timescale 1ns/100ps
`default_nettype none

module enigma_cipher import enigma_pkg::*; (
    input  wire logic          CLOCK_50,
    input  wire logic          i_rst_n,
    input  wire logic          i_encipher,
    input  wire shown_letter_t i_plain,
    input  wire rotor_set_t    i_rotors,
    output shown_letter_t      o_cipher,
    output lamp_t              o_lamp
);

    function automatic letter_t add_mod(input letter_t a, input letter_t b);
        logic [5:0] sum;
        sum = a + b;
        return (sum >= NUM_LETTERS) ? letter_t'(sum - NUM_LETTERS) : sum[4:0];
    endfunction

    function automatic letter_t sub_mod(input letter_t a, input letter_t b);
        return (a >= b) ? a - b : letter_t'(a + NUM_LETTERS - b);
    endfunction

    // one rotor pass, inverse searches the forward wiring
    function automatic letter_t pass(input letter_t c, input rotor_cfg_t r, input logic inv);
        letter_t ofs;
        letter_t pin;
        letter_t out;
        ofs = sub_mod(r.position, r.ring);
        pin = add_mod(c, ofs);
        out = 5'd0;
        if (!inv) begin
            out = to_letter(ROTOR_WIRING[r.number][pin]);
        end else begin
            for (int j = 0; j < NUM_LETTERS; j++) begin
                if (to_letter(ROTOR_WIRING[r.number][j]) == pin) out = letter_t'(j);
            end
        end
        return sub_mod(out, ofs);
    endfunction

    rotor_set_t stepped;
    letter_t    fwd;
    letter_t    refl;
    letter_t    result;

    // same stepped positions rotor_settings loads this edge
    assign stepped = step_rotors(i_rotors);
    assign fwd     = pass(pass(pass(i_plain.letter, stepped.right, 1'b0),
                               stepped.middle, 1'b0), stepped.left, 1'b0);
    assign refl    = to_letter(REFLECTOR_B[fwd]);
    assign result  = pass(pass(pass(refl, stepped.left, 1'b1),
                               stepped.middle, 1'b1), stepped.right, 1'b1);

    always_ff @(posedge CLOCK_50) begin
        if (!i_rst_n) begin
            o_cipher <= '0;
            o_lamp   <= '0;
        end else if (i_encipher && i_plain.shown) begin
            o_cipher <= '{shown: 1'b1, letter: result};
            o_lamp   <= lamp_t'(1) << result;
        end
    end

endmodule

`default_nettype wire

/* rotor_settings.sv */
`timescale 1ns/100ps
`default_nettype none

module rotor_settings import enigma_pkg::*; (
    input  wire logic                       CLOCK_50,
    input  wire logic                       i_rst_n,
    input  wire logic [NUM_SET_BUTTONS-1:0] i_press,
    input  wire logic                       i_step,
    output rotor_set_t                      o_rotors
);

    // I..V then back to I
    function automatic rotor_num_t next_num(input rotor_num_t n);
        return (n == rotor_num_t'(NUM_ROTORS_AVAIL - 1)) ? 3'd0 : n + 3'd1;
    endfunction

    always_ff @(posedge CLOCK_50) begin
        if (!i_rst_n) begin
            o_rotors <= RESET_ROTORS;
        end else if (i_step) begin
            // keypress stepping beats a button on the same edge
            o_rotors <= step_rotors(o_rotors);
        end else begin
            // right rotor buttons
            if (i_press[0]) o_rotors.right.number    <= next_num(o_rotors.right.number);
            if (i_press[1]) o_rotors.right.position  <= next_letter(o_rotors.right.position);
            if (i_press[2]) o_rotors.right.ring      <= next_letter(o_rotors.right.ring);
            // middle rotor buttons
            if (i_press[3]) o_rotors.middle.number   <= next_num(o_rotors.middle.number);
            if (i_press[4]) o_rotors.middle.position <= next_letter(o_rotors.middle.position);
            if (i_press[5]) o_rotors.middle.ring     <= next_letter(o_rotors.middle.ring);
            // left rotor, ring has no button and stays at A
            if (i_press[6]) o_rotors.left.number     <= next_num(o_rotors.left.number);
            if (i_press[7]) o_rotors.left.position   <= next_letter(o_rotors.left.position);
        end
    end

endmodule

`default_nettype wire

/* scan_to_letter.sv */
`timescale 1ns/100ps
`default_nettype none

module scan_to_letter import enigma_pkg::*; (
    input  wire logic [7:0]    i_scan_code,
    output shown_letter_t      o_plain
);

    // set 2 make codes of the letter keys
    always_comb begin
        o_plain.shown = 1'b1;
        case (i_scan_code)
            8'h1C: o_plain.letter = 5'd0;
            8'h32: o_plain.letter = 5'd1;
            8'h21: o_plain.letter = 5'd2;
            8'h23: o_plain.letter = 5'd3;
            8'h24: o_plain.letter = 5'd4;
            8'h2B: o_plain.letter = 5'd5;
            8'h34: o_plain.letter = 5'd6;
            8'h33: o_plain.letter = 5'd7;
            8'h43: o_plain.letter = 5'd8;
            8'h3B: o_plain.letter = 5'd9;
            8'h42: o_plain.letter = 5'd10;
            8'h4B: o_plain.letter = 5'd11;
            8'h3A: o_plain.letter = 5'd12;
            8'h31: o_plain.letter = 5'd13;
            8'h44: o_plain.letter = 5'd14;
            8'h4D: o_plain.letter = 5'd15;
            8'h15: o_plain.letter = 5'd16;
            8'h2D: o_plain.letter = 5'd17;
            8'h1B: o_plain.letter = 5'd18;
            8'h2C: o_plain.letter = 5'd19;
            8'h3C: o_plain.letter = 5'd20;
            8'h2A: o_plain.letter = 5'd21;
            8'h1D: o_plain.letter = 5'd22;
            8'h22: o_plain.letter = 5'd23;
            8'h35: o_plain.letter = 5'd24;
            8'h1A: o_plain.letter = 5'd25;
            default: begin
                // digits, shift, F0 and the rest
                o_plain.shown  = 1'b0;
                o_plain.letter = 5'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* key_press_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module key_press_fsm import enigma_pkg::*; #(
    parameter int HOLDOFF_CYCLES = 5000
) (
    input  wire logic       CLOCK_50,
    input  wire logic       i_rst_n,
    input  wire logic [7:0] i_scan_code,
    input  wire logic       i_scan_strobe,
    input  wire logic       i_plain_shown,
    output logic      [7:0] o_held_code,
    output logic            o_encipher
);

    localparam int CNT_W = $clog2(HOLDOFF_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MAKE,
        ST_BREAK,
        ST_WAIT
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] holdoff_cnt;

    always_ff @(posedge CLOCK_50) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            holdoff_cnt <= '0;
            // code 00 maps to no letter, keeps HEX0 blank
            o_held_code <= 8'h00;
            o_encipher  <= 1'b0;
        end else begin
            o_encipher <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // first byte of a press is the make code
                    if (i_scan_strobe) begin
                        o_held_code <= i_scan_code;
                        state       <= ST_MAKE;
                    end
                end
                ST_MAKE: begin
                    // typematic repeats just keep us here
                    if (i_scan_strobe && (i_scan_code == SCAN_BREAK)) begin
                        state <= ST_BREAK;
                    end
                end
                ST_BREAK: begin
                    if (i_scan_strobe && (i_scan_code == o_held_code)) begin
                        // only letters get enciphered
                        o_encipher  <= i_plain_shown;
                        holdoff_cnt <= '0;
                        state       <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // strobes dropped here
                    if (holdoff_cnt == CNT_W'(HOLDOFF_CYCLES)) begin
                        state <= ST_IDLE;
                    end else begin
                        holdoff_cnt <= holdoff_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* button_press.sv */
`timescale 1ns/100ps
`default_nettype none

module button_press import enigma_pkg::*; (
    input  wire logic                       CLOCK_50,
    input  wire logic                       i_rst_n,
    input  wire logic [NUM_SET_BUTTONS-1:0] i_btn_n,
    output logic      [NUM_SET_BUTTONS-1:0] o_press
);

    // two flop synchronizer, then last level for edge detect
    logic [NUM_SET_BUTTONS-1:0] sync_1;
    logic [NUM_SET_BUTTONS-1:0] sync_2;
    logic [NUM_SET_BUTTONS-1:0] last_level;

    always_ff @(posedge CLOCK_50) begin
        if (!i_rst_n) begin
            // released level, so a held button gives no pulse
            sync_1     <= '1;
            sync_2     <= '1;
            last_level <= '1;
            o_press    <= '0;
        end else begin
            sync_1     <= i_btn_n;
            sync_2     <= sync_1;
            last_level <= sync_2;
            // high to low on the synced line
            o_press    <= last_level & ~sync_2;
        end
    end

endmodule

`default_nettype wire

/* enigma_pkg.sv */
`default_nettype none

package enigma_pkg;

    localparam int NUM_LETTERS      = 26;
    localparam int NUM_ROTORS_AVAIL = 5;
    localparam int NUM_SET_BUTTONS  = 8;

    // letter A..Z as 0..25
    typedef logic [4:0] letter_t;
    // rotor I..V as 0..4
    typedef logic [2:0] rotor_num_t;
    // bit n lights lamp for letter n
    typedef logic [NUM_LETTERS-1:0] lamp_t;

    typedef struct packed {
        rotor_num_t number;
        letter_t    ring;
        letter_t    position;
    } rotor_cfg_t;

    typedef struct packed {
        rotor_cfg_t left;
        rotor_cfg_t middle;
        rotor_cfg_t right;
    } rotor_set_t;

    typedef struct packed {
        logic    shown;
        letter_t letter;
    } shown_letter_t;

    // ascii tables, entry 0 is the leftmost character
    localparam logic [0:NUM_ROTORS_AVAIL-1][0:NUM_LETTERS-1][7:0] ROTOR_WIRING = {
        "EKMFLGDQVZNTOWYHXUSPAIBRCJ",
        "AJDKSIRUXBLHWTMCQGZNPYFVOE",
        "BDFHJLCPRTXVZNYEIWGAKMUSQO",
        "ESOVPZJAYQUIRHXLNFTGKDCMWB",
        "VZBRGITYUPSDNHLXAWMJQOFECK"
    };
    // turnover letter per rotor
    localparam logic [0:NUM_ROTORS_AVAIL-1][7:0] ROTOR_NOTCH = "QEVJZ";
    localparam logic [0:NUM_LETTERS-1][7:0] REFLECTOR_B = "YRUHQSLDPXNGOKMIEBFZCWVJAT";

    // active low, bit 6 is g down to bit 0 is a
    localparam logic [0:NUM_LETTERS-1][6:0] SEG7_GLYPH = {
        7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E, 7'h42, 7'h09, 7'h4F,
        7'h61, 7'h0A, 7'h47, 7'h6A, 7'h2B, 7'h23, 7'h0C, 7'h18, 7'h2F,
        7'h12, 7'h07, 7'h41, 7'h63, 7'h55, 7'h49, 7'h11, 7'h24
    };
    localparam logic [6:0] SEG7_BLANK = 7'h7F;

    localparam logic [7:0] SCAN_BREAK = 8'hF0;

    // rotors I, II, III left to right, rings and positions at A
    localparam rotor_set_t RESET_ROTORS = '{
        left:   '{number: 3'd0, ring: 5'd0, position: 5'd0},
        middle: '{number: 3'd1, ring: 5'd0, position: 5'd0},
        right:  '{number: 3'd2, ring: 5'd0, position: 5'd0}
    };

    // ascii capital to letter index
    function automatic letter_t to_letter(input logic [7:0] c);
        logic [7:0] d;
        d = c - 8'h41;
        return d[4:0];
    endfunction

    function automatic letter_t next_letter(input letter_t l);
        return (l == letter_t'(NUM_LETTERS - 1)) ? 5'd0 : l + 5'd1;
    endfunction

    // one key press worth of stepping, double step included
    function automatic rotor_set_t step_rotors(input rotor_set_t r);
        rotor_set_t s;
        logic       right_at_notch;
        logic       mid_at_notch;
        s = r;
        right_at_notch = (r.right.position == to_letter(ROTOR_NOTCH[r.right.number]));
        mid_at_notch   = (r.middle.position == to_letter(ROTOR_NOTCH[r.middle.number]));
        s.right.position = next_letter(r.right.position);
        // middle also moves when sitting on its own notch
        if (right_at_notch || mid_at_notch) begin
            s.middle.position = next_letter(r.middle.position);
        end
        if (mid_at_notch) begin
            s.left.position = next_letter(r.left.position);
        end
        return s;
    endfunction

endpackage

`default_nettype wire
